//--- design/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath widths
`define WORD_W      32
`define REG_ADDR_W  4
`define REG_COUNT   16
`define IMM_W       20
`define ALU_OP_W    5
`define FLAGS_W     4

// Flag bit positions
`define FLAG_C      3
`define FLAG_Z      2
`define FLAG_N      1
`define FLAG_V      0

// ALU operation codes
`define ALU_ADD     5'd0
`define ALU_SUB     5'd1
`define ALU_AND     5'd2
`define ALU_OR      5'd3
`define ALU_XOR     5'd4
`define ALU_NOT     5'd5
`define ALU_CMP     5'd14
`define ALU_TST     5'd15
`define ALU_ADC     5'd16
`define ALU_SBC     5'd17
`define ALU_BSWAP   5'd18
// Internal op for plain direct loads
`define ALU_PASSB   5'd31

`define ALU_DEFAULT 32'h0BADC0DE

// Core operation field value
`define CORE_HALT   6'd2

`endif

//--- design/cpuPkg.sv
`default_nettype none

`include "cpu_consts.svh"

package cpuPkg;

    typedef logic [`WORD_W-1:0]     word_t;
    typedef logic [`REG_ADDR_W-1:0] regAddr_t;
    typedef logic [`ALU_OP_W-1:0]   aluOp_t;

    // Carry, zero, negative, overflow from msb down
    typedef logic [`FLAGS_W-1:0]    flags_t;

    typedef enum logic [2:0] {
        stFetch,
        stDecode,
        stExecute,
        stMemory,
        stWriteback,
        stHalt
    } pipeState_t;

endpackage

`default_nettype wire

//--- design/decodeIf.sv
`timescale 1ns/1ps
`default_nettype none

interface decodeIf;
    import cpuPkg::*;

    // Instruction class
    logic isBranch, isLoad, isStore, isDirect, isDirectOr;
    logic isAlu, isMove, isSwap, isHalt;

    logic [3:0] cond;
    regAddr_t   rdA, rdB, wrA, wrB;
    logic       wantWrA, wantWrB;
    aluOp_t     aluOp;
    word_t      immB;
    logic       useImm, setsFlags;

    modport dec (
        output isBranch, isLoad, isStore, isDirect, isDirectOr,
        output isAlu, isMove, isSwap, isHalt,
        output cond, rdA, rdB, wrA, wrB, wantWrA, wantWrB,
        output aluOp, immB, useImm, setsFlags
    );

    modport user (
        input isBranch, isLoad, isStore, isDirect, isDirectOr,
        input isAlu, isMove, isSwap, isHalt,
        input cond, rdA, rdB, wrA, wrB, wantWrA, wantWrB,
        input aluOp, immB, useImm, setsFlags
    );

endinterface

`default_nettype wire

//--- design/instDecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module instDecode (
    input  cpuPkg::word_t inst,
    decodeIf.dec          dec
);
    import cpuPkg::*;

    logic  isBranchCls, isMemCls, isDirectCls, isAluCls, isRegCls, isCoreCls;
    word_t offsetExt, directVal, aluVal;

    // Leading opcode bits, anything else is a no-op
    assign isBranchCls = inst[31:28] == 4'b1000;
    assign isMemCls    = inst[31:30] == 2'b01;
    assign isDirectCls = inst[31:29] == 3'b001;
    assign isAluCls    = inst[31:28] == 4'b0001;
    assign isRegCls    = inst[31:27] == 5'b00001;
    assign isCoreCls   = inst[31:26] == 6'b000001;

    assign dec.isBranch   = isBranchCls;
    assign dec.isLoad     = isMemCls && !inst[29];
    assign dec.isStore    = isMemCls && inst[29];
    assign dec.isDirect   = isDirectCls;
    assign dec.isDirectOr = isDirectCls && inst[28];
    assign dec.isAlu      = isAluCls;
    assign dec.isMove     = isRegCls && !inst[24];
    assign dec.isSwap     = isRegCls && inst[24];
    assign dec.isHalt     = isCoreCls && (inst[25:20] == `CORE_HALT);
    assign dec.cond       = inst[27:24];

    always_comb begin
        dec.rdA = '0;
        dec.rdB = '0;
        dec.wrA = '0;
        dec.wrB = '0;
        if (isBranchCls) begin
            dec.rdA = inst[23:20];
        end else if (isMemCls) begin
            dec.rdA = inst[27:24];
            dec.rdB = inst[23:20];
            dec.wrA = inst[23:20];
        end else if (isDirectCls) begin
            dec.rdA = inst[27:24];
            dec.wrB = inst[27:24];
        end else if (isAluCls) begin
            dec.rdA = inst[15:12];
            dec.rdB = inst[11:8];
            dec.wrA = inst[19:16];
        end else if (isRegCls) begin
            // Destination on A and B read sides, source swapped on write
            dec.rdA = inst[23:20];
            dec.rdB = inst[19:16];
            dec.wrA = inst[19:16];
            dec.wrB = inst[23:20];
        end
    end

    assign dec.wantWrA = isAluCls || (isMemCls && !inst[29]) || (isRegCls && inst[24]);
    assign dec.wantWrB = isDirectCls || isRegCls;

    // Immediate forms, shifts count in pairs of bits
    assign offsetExt = {{(`WORD_W - `IMM_W){inst[`IMM_W-1]}}, inst[`IMM_W-1:0]};
    assign directVal = word_t'(inst[`IMM_W-1:0]) << {inst[23:20], 1'b0};
    assign aluVal    = word_t'(inst[7:0]) << {inst[11:8], 1'b0};

    assign dec.immB = isDirectCls ? directVal : (isAluCls ? aluVal : offsetExt);

    assign dec.useImm    = isBranchCls || isMemCls || isDirectCls || (isAluCls && inst[27]);
    assign dec.setsFlags = isAluCls;

    always_comb begin
        if (isAluCls) begin
            dec.aluOp = aluOp_t'(inst[24:20]);
        end else if (isDirectCls) begin
            dec.aluOp = inst[28] ? `ALU_OR : `ALU_PASSB;
        end else begin
            // Branch targets and memory addresses
            dec.aluOp = `ALU_ADD;
        end
    end

endmodule

`default_nettype wire

//--- design/pipeCtrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module pipeCtrl (
    input  logic               iClk,
    input  logic               rstN,
    decodeIf.user              dec,
    input  cpuPkg::flags_t     flags,
    input  logic               memReady,
    output cpuPkg::pipeState_t state,
    output logic               execTaken,
    output logic               memAccess,
    output logic               memWrite,
    output logic               halt
);
    import cpuPkg::*;

    pipeState_t nextState;
    logic       memOp;
    logic       condMet;
    logic       c, z, n, v;

    assign memOp = dec.isLoad || dec.isStore;

    always_ff @(posedge iClk) begin
        if (!rstN) begin
            state <= stFetch;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        case (state)
            stFetch:     nextState = memReady ? stDecode : stFetch;
            stDecode:    nextState = stExecute;
            stExecute:   nextState = stMemory;
            // Non-memory instructions pass through in one cycle
            stMemory:    nextState = (!memOp || memReady) ? stWriteback : stMemory;
            stWriteback: nextState = dec.isHalt ? stHalt : stFetch;
            stHalt:      nextState = stHalt;
            default:     nextState = stFetch;
        endcase
    end

    assign c = flags[`FLAG_C];
    assign z = flags[`FLAG_Z];
    assign n = flags[`FLAG_N];
    assign v = flags[`FLAG_V];

    // Branch condition table
    always_comb begin
        case (dec.cond)
            4'd0:    condMet = 1'b1;
            4'd1:    condMet = z;
            4'd2:    condMet = !z;
            4'd3:    condMet = c;
            4'd4:    condMet = !c;
            4'd5:    condMet = n;
            4'd6:    condMet = !n;
            4'd7:    condMet = v;
            4'd8:    condMet = !v;
            4'd9:    condMet = c && !z;
            4'd10:   condMet = !c || z;
            4'd11:   condMet = n == v;
            4'd12:   condMet = n != v;
            4'd13:   condMet = !z && (n == v);
            4'd14:   condMet = z || (n != v);
            default: condMet = 1'b0;
        endcase
    end

    assign execTaken = dec.isBranch && condMet;

    assign memAccess = (state == stFetch) || (state == stMemory && memOp);
    assign memWrite  = (state == stMemory) && dec.isStore;
    assign halt      = state == stHalt;

endmodule

`default_nettype wire

//--- design/regFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module regFile (
    input  logic             iClk,
    input  cpuPkg::word_t    ip,
    input  cpuPkg::regAddr_t rdA,
    input  cpuPkg::regAddr_t rdB,
    output cpuPkg::word_t    rdDataA,
    output cpuPkg::word_t    rdDataB,
    input  cpuPkg::regAddr_t wrA,
    input  cpuPkg::regAddr_t wrB,
    input  logic             wrEnA,
    input  logic             wrEnB,
    input  cpuPkg::word_t    wrDataA,
    input  cpuPkg::word_t    wrDataB
);
    import cpuPkg::*;

    word_t regs [`REG_COUNT] = '{default: '0};

    always_ff @(posedge iClk) begin
        if (wrEnA && (wrA != '0)) begin
            regs[wrA] <= wrDataA;
        end
        // Later assignment lets port B win
        if (wrEnB && (wrB != '0)) begin
            regs[wrB] <= wrDataB;
        end
    end

    // Register 0 aliases the IP
    assign rdDataA = (rdA == '0) ? ip : regs[rdA];
    assign rdDataB = (rdB == '0) ? ip : regs[rdB];

endmodule

`default_nettype wire

//--- design/aluFlags.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module aluFlags (
    input  logic               iClk,
    input  logic               rstN,
    input  cpuPkg::pipeState_t state,
    decodeIf.user              dec,
    input  cpuPkg::word_t      opA,
    input  cpuPkg::word_t      opB,
    output cpuPkg::word_t      result,
    output cpuPkg::flags_t     flags
);
    import cpuPkg::*;

    logic [`WORD_W:0] aluOut;
    logic [`WORD_W:0] carryIn;
    logic             carryNew, overNew;

    assign carryIn = (`WORD_W + 1)'(flags[`FLAG_C]);

    always_comb begin
        case (dec.aluOp)
            `ALU_ADD:           aluOut = {1'b0, opA} + {1'b0, opB};
            `ALU_SUB, `ALU_CMP: aluOut = {1'b0, opA} - {1'b0, opB};
            `ALU_AND, `ALU_TST: aluOut = {1'b0, opA & opB};
            `ALU_OR:            aluOut = {1'b0, opA | opB};
            `ALU_XOR:           aluOut = {1'b0, opA ^ opB};
            `ALU_NOT:           aluOut = {1'b0, ~opA};
            `ALU_ADC:           aluOut = {1'b0, opA} + {1'b0, opB} + carryIn;
            `ALU_SBC:           aluOut = {1'b0, opA} - ({1'b0, opB} + carryIn);
            `ALU_BSWAP:         aluOut = {1'b0, opA[7:0], opA[15:8], opA[23:16], opA[31:24]};
            `ALU_PASSB:         aluOut = {1'b0, opB};
            default:            aluOut = {1'b0, `ALU_DEFAULT};
        endcase
    end

    // Borrow shows up as an inverted carry
    always_comb begin
        case (dec.aluOp)
            `ALU_ADD, `ALU_ADC:           carryNew = aluOut[`WORD_W];
            `ALU_SUB, `ALU_CMP, `ALU_SBC: carryNew = !aluOut[`WORD_W];
            default:                      carryNew = 1'b0;
        endcase
    end

    always_comb begin
        case (dec.aluOp)
            `ALU_ADD: overNew = (opA[`WORD_W-1] == opB[`WORD_W-1])
                                && (aluOut[`WORD_W-1] != opA[`WORD_W-1]);
            `ALU_SUB: overNew = (opA[`WORD_W-1] != opB[`WORD_W-1])
                                && (aluOut[`WORD_W-1] != opA[`WORD_W-1]);
            default:  overNew = 1'b0;
        endcase
    end

    // Operands still hold at writeback, so aluOut is the executed value
    always_ff @(posedge iClk) begin
        if (!rstN) begin
            flags <= '0;
        end else if ((state == stWriteback) && dec.setsFlags) begin
            flags[`FLAG_C] <= carryNew;
            flags[`FLAG_Z] <= aluOut[`WORD_W-1:0] == '0;
            flags[`FLAG_N] <= aluOut[`WORD_W-1];
            flags[`FLAG_V] <= overNew;
        end
    end

    assign result = aluOut[`WORD_W-1:0];

endmodule

`default_nettype wire

//--- design/dataPath.sv
`timescale 1ns/1ps
`default_nettype none

module dataPath (
    input  logic               iClk,
    input  logic               rstN,
    input  cpuPkg::pipeState_t state,
    input  logic               execTaken,
    decodeIf.user              dec,
    input  cpuPkg::word_t      result,
    output cpuPkg::word_t      opA,
    output cpuPkg::word_t      opB,
    output cpuPkg::word_t      ip,
    output cpuPkg::regAddr_t   rdA,
    output cpuPkg::regAddr_t   rdB,
    input  cpuPkg::word_t      rdDataA,
    input  cpuPkg::word_t      rdDataB,
    output cpuPkg::regAddr_t   wrA,
    output cpuPkg::regAddr_t   wrB,
    output logic               wrEnA,
    output logic               wrEnB,
    output cpuPkg::word_t      wrDataA,
    output cpuPkg::word_t      wrDataB,
    output cpuPkg::word_t      memAddr,
    output cpuPkg::word_t      memWdata,
    input  cpuPkg::word_t      memRdata,
    input  logic               memReady,
    output cpuPkg::word_t      inst
);
    import cpuPkg::*;

    word_t aReg, bReg, mReg, rReg;

    always_ff @(posedge iClk) begin
        if (!rstN) begin
            ip   <= '0;
            inst <= '0;
        end else begin
            if ((state == stFetch) && memReady) begin
                inst <= memRdata;
            end
            if (state == stWriteback) begin
                ip <= execTaken ? rReg : ip + 1'b1;
            end
        end
    end

    always_ff @(posedge iClk) begin
        if (state == stDecode) begin
            aReg <= rdDataA;
            bReg <= dec.useImm ? dec.immB : rdDataB;
            // Store data rides in M until the memory stage
            mReg <= rdDataB;
        end
        if (state == stExecute) begin
            rReg <= result;
        end
        if ((state == stMemory) && memReady && dec.isLoad) begin
            mReg <= memRdata;
        end
    end

    assign opA      = aReg;
    assign opB      = bReg;
    assign memAddr  = (state == stFetch) ? ip : rReg;
    assign memWdata = mReg;

    assign rdA   = dec.rdA;
    assign rdB   = dec.rdB;
    assign wrA   = dec.wrA;
    assign wrB   = dec.wrB;
    assign wrEnA = (state == stWriteback) && dec.wantWrA;
    assign wrEnB = (state == stWriteback) && dec.wantWrB;

    // Writeback sources per class
    always_comb begin
        wrDataA = rReg;
        wrDataB = rReg;
        unique case (1'b1)
            dec.isAlu:    wrDataA = rReg;
            dec.isLoad:   wrDataA = mReg;
            dec.isMove:   wrDataB = bReg;
            dec.isSwap: begin
                wrDataA = aReg;
                wrDataB = bReg;
            end
            // Plain direct writes the shifted value straight through
            dec.isDirect: wrDataB = dec.isDirectOr ? rReg : bReg;
            default:      wrDataA = rReg;
        endcase
    end

endmodule

`default_nettype wire

//--- design/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore (
    input  logic          iClk,
    input  logic          rstN,
    output cpuPkg::word_t memAddr,
    output cpuPkg::word_t memWdata,
    output logic          memWrite,
    output logic          memAccess,
    input  cpuPkg::word_t memRdata,
    input  logic          memReady,
    output logic          halt
);
    import cpuPkg::*;

    pipeState_t state;
    flags_t     flags;
    logic       execTaken;
    word_t      inst, result, opA, opB, ip;
    word_t      rdDataA, rdDataB, wrDataA, wrDataB;
    regAddr_t   rdA, rdB, wrA, wrB;
    logic       wrEnA, wrEnB;

    decodeIf decBus ();

    instDecode uDecode (
        .inst (inst),
        .dec  (decBus)
    );

    pipeCtrl uCtrl (
        .iClk      (iClk),
        .rstN      (rstN),
        .dec       (decBus),
        .flags     (flags),
        .memReady  (memReady),
        .state     (state),
        .execTaken (execTaken),
        .memAccess (memAccess),
        .memWrite  (memWrite),
        .halt      (halt)
    );

    regFile uRegs (
        .iClk    (iClk),
        .ip      (ip),
        .rdA     (rdA),
        .rdB     (rdB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .wrA     (wrA),
        .wrB     (wrB),
        .wrEnA   (wrEnA),
        .wrEnB   (wrEnB),
        .wrDataA (wrDataA),
        .wrDataB (wrDataB)
    );

    aluFlags uAlu (
        .iClk   (iClk),
        .rstN   (rstN),
        .state  (state),
        .dec    (decBus),
        .opA    (opA),
        .opB    (opB),
        .result (result),
        .flags  (flags)
    );

    dataPath uPath (
        .iClk      (iClk),
        .rstN      (rstN),
        .state     (state),
        .execTaken (execTaken),
        .dec       (decBus),
        .result    (result),
        .opA       (opA),
        .opB       (opB),
        .ip        (ip),
        .rdA       (rdA),
        .rdB       (rdB),
        .rdDataA   (rdDataA),
        .rdDataB   (rdDataB),
        .wrA       (wrA),
        .wrB       (wrB),
        .wrEnA     (wrEnA),
        .wrEnB     (wrEnB),
        .wrDataA   (wrDataA),
        .wrDataB   (wrDataB),
        .memAddr   (memAddr),
        .memWdata  (memWdata),
        .memRdata  (memRdata),
        .memReady  (memReady),
        .inst      (inst)
    );

endmodule

`default_nettype wire

//--- sim/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic iClk,
    output logic rstN
);

    // 40 ns period
    initial begin
        iClk = 1'b0;
        forever #20 iClk = ~iClk;
    end

    initial begin
        rstN = 1'b0;
        repeat (2) @(posedge iClk);
        #2;
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

//--- sim/cpu_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cpuAssert (
    input logic          iClk,
    input logic          rstN,
    input cpuPkg::word_t memAddr,
    input cpuPkg::word_t memWdata,
    input logic          memWrite,
    input logic          memAccess,
    input logic          memReady,
    input logic          halt
);

    // Failed assertions, summed into the testbench error count
    int failCount = 0;

    writeNeedsAccess: assert property (@(posedge iClk) disable iff (!rstN)
        memWrite |-> memAccess)
        else begin
            failCount++;
            $error("memWrite high without memAccess");
        end

    haltQuiet: assert property (@(posedge iClk) disable iff (!rstN)
        halt |-> !memAccess)
        else begin
            failCount++;
            $error("memAccess high while halted");
        end

    haltSticky: assert property (@(posedge iClk) disable iff (!rstN)
        halt |=> halt)
        else begin
            failCount++;
            $error("halt dropped before reset");
        end

    // A waiting access keeps the whole bus still
    busHold: assert property (@(posedge iClk) disable iff (!rstN)
        (memAccess && !memReady) |=> memAccess && $stable(memAddr) && $stable(memWdata))
        else begin
            failCount++;
            $error("bus outputs changed while an access waited");
        end

endmodule

bind cpuCore cpuAssert uAssert (
    .iClk      (iClk),
    .rstN      (rstN),
    .memAddr   (memAddr),
    .memWdata  (memWdata),
    .memWrite  (memWrite),
    .memAccess (memAccess),
    .memReady  (memReady),
    .halt      (halt)
);

`default_nettype wire

//--- sim/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module cpuTb;
    import cpuPkg::*;

    // 200 instructions at 5 cycles plus two accesses of up to 6 stall cycles each
    localparam int maxCycles = 4000;
    localparam int resBase   = 'hB0;

    logic  iClk, rstN, memWrite, memAccess, memReady, halt;
    word_t memAddr, memWdata, memRdata;
    word_t mem [256];
    word_t refMem [256];
    word_t prog [$];
    word_t expAddr [$];
    word_t expData [$];
    int    resSlot, storeIdx, checks, errors, cycles, i;

    tbClock uClock (
        .iClk (iClk),
        .rstN (rstN)
    );

    cpuCore i_cpuCore (
        .iClk      (iClk),
        .rstN      (rstN),
        .memAddr   (memAddr),
        .memWdata  (memWdata),
        .memWrite  (memWrite),
        .memAccess (memAccess),
        .memRdata  (memRdata),
        .memReady  (memReady),
        .halt      (halt)
    );

    function automatic word_t encAlu(input logic [4:0] op, input logic [3:0] rd,
                                     input logic [3:0] ra, input logic [3:0] rb,
                                     input logic useImm, input logic [7:0] imm);
        return {4'b0001, useImm, 2'b00, op, rd, ra, rb, imm};
    endfunction

    function automatic word_t encMem(input logic store, input logic [3:0] base,
                                     input logic [3:0] data, input logic [19:0] off);
        return {2'b01, store, 1'b0, base, data, off};
    endfunction

    function automatic word_t encDirect(input logic orForm, input logic [3:0] rd,
                                        input logic [3:0] shift, input logic [19:0] imm);
        return {3'b001, orForm, rd, shift, imm};
    endfunction

    function automatic word_t encBranch(input logic [3:0] cond, input logic [3:0] ra,
                                        input logic [19:0] off);
        return {4'b1000, cond, ra, off};
    endfunction

    // Move copies y into x, swap exchanges them
    function automatic word_t encReg(input logic swap, input logic [3:0] x,
                                     input logic [3:0] y);
        return {5'b00001, 2'b00, swap, x, y, 16'h0000};
    endfunction

    function automatic logic condHolds(input logic [3:0] cond, input logic c, input logic z,
                                       input logic n, input logic v);
        logic [15:0] tbl;
        tbl = {1'b0, z | (n ^ v), ~z & ~(n ^ v), n ^ v, ~(n ^ v), ~c | z, c & ~z,
               ~v, v, ~n, n, ~c, c, ~z, z, 1'b1};
        return tbl[cond];
    endfunction

    task automatic appendInst(input word_t w);
        prog.push_back(w);
    endtask

    task automatic appendStore(input logic [3:0] rs);
        appendInst(encMem(1'b1, 4'd1, rs, 20'(resSlot)));
        resSlot++;
    endtask

    task automatic buildProgram();
        int k;
        int shifts [4] = '{0, 3, 7, 15};
        int pairA [4] = '{3, 4, 3, 13};
        int pairB [4] = '{4, 3, 3, 14};
        logic [4:0] ops [11] = '{`ALU_ADD, `ALU_ADC, `ALU_SUB, `ALU_SBC, `ALU_AND, `ALU_OR,
                                 `ALU_XOR, `ALU_NOT, `ALU_CMP, `ALU_TST, `ALU_BSWAP};
        resSlot = 0;
        // r1 results, r2 operands, r13 and r14 force signed overflow
        appendInst(encDirect(1'b0, 4'd1, 4'd0, 20'(resBase)));
        appendInst(encDirect(1'b0, 4'd2, 4'd0, 20'hF0));
        appendInst(encMem(1'b0, 4'd2, 4'd3, 20'd0));
        appendInst(encMem(1'b0, 4'd2, 4'd4, 20'd1));
        appendInst(encDirect(1'b0, 4'd13, 4'd15, 20'd2));
        appendInst(encDirect(1'b0, 4'd14, 4'd0, 20'd1));
        // adc and sbc follow add and sub, so they chain on carry
        for (k = 0; k < 11; k++) begin
            appendInst(encAlu(ops[k], 4'd8, 4'd3, 4'd4, 1'b0, 8'h00));
            appendStore(4'd8);
            appendInst(encAlu(ops[k], 4'd8, 4'd3, 4'($urandom), 1'b1, 8'($urandom)));
            appendStore(4'd8);
        end
        for (k = 0; k < 4; k++) begin
            appendInst(encDirect(1'b0, 4'd9, 4'(shifts[k]), 20'($urandom)));
            appendStore(4'd9);
            appendInst(encDirect(1'b1, 4'd9, 4'(shifts[k]), 20'($urandom)));
            appendStore(4'd9);
        end
        // Offsets below and above a base, then addressing off the IP
        appendInst(encDirect(1'b0, 4'd6, 4'd0, 20'hF4));
        appendInst(encMem(1'b0, 4'd6, 4'd5, 20'hFFFFD));
        appendStore(4'd5);
        appendInst(encMem(1'b1, 4'd6, 4'd3, 20'd4));
        appendInst(encMem(1'b0, 4'd0, 4'd7, 20'('hF2 - prog.size())));
        appendInst(encMem(1'b1, 4'd0, 4'd7, 20'(resBase + resSlot - prog.size())));
        resSlot++;
        // Not-taken path inverts the marker
        for (k = 0; k < 16; k++) begin
            appendInst(encAlu(`ALU_SUB, 4'd11, 4'(pairA[k % 4]), 4'(pairB[k % 4]), 1'b0, 8'h00));
            appendInst(encBranch(4'(k), 4'd0, 20'd2));
            appendInst(encAlu(`ALU_NOT, 4'd11, 4'd11, 4'd0, 1'b0, 8'h00));
            appendStore(4'd11);
        end
        appendInst(encDirect(1'b0, 4'd15, 4'd0, 20'd5));
        appendInst(encAlu(`ALU_SUB, 4'd15, 4'd15, 4'd0, 1'b1, 8'd1));
        appendStore(4'd15);
        appendInst(encBranch(4'd2, 4'd0, 20'hFFFFE));
        appendInst(encReg(1'b0, 4'd9, 4'd3));
        appendStore(4'd9);
        appendInst(encReg(1'b1, 4'd3, 4'd4));
        appendStore(4'd3);
        appendStore(4'd4);
        appendInst(encReg(1'b1, 4'd5, 4'd5));
        appendStore(4'd5);
        appendInst(32'h0000_0000);
        appendInst({6'b000001, `CORE_HALT, 20'h00000});
    endtask

    // ISA model over refMem, fills the expected store list
    function automatic void refRun();
        word_t       r [16];
        word_t       pc, nextPc, ins, a, b, res, addr;
        logic [63:0] sum;
        logic        cF, zF, nF, vF, cN, vN, done;
        int          steps;
        r = '{default: '0};
        pc = '0;
        {cF, zF, nF, vF} = 4'b0000;
        done = 1'b0;
        for (steps = 0; steps < 400 && !done; steps++) begin
            ins = refMem[pc[7:0]];
            r[0] = pc;
            nextPc = pc + 1;
            if (ins[31:28] == 4'b1000) begin
                if (condHolds(ins[27:24], cF, zF, nF, vF)) begin
                    nextPc = r[ins[23:20]] + {{12{ins[19]}}, ins[19:0]};
                end
            end else if (ins[31:30] == 2'b01) begin
                addr = r[ins[27:24]] + {{12{ins[19]}}, ins[19:0]};
                if (ins[29]) begin
                    refMem[addr[7:0]] = r[ins[23:20]];
                    expAddr.push_back(addr);
                    expData.push_back(r[ins[23:20]]);
                end else if (ins[23:20] != 0) begin
                    r[ins[23:20]] = refMem[addr[7:0]];
                end
            end else if (ins[31:29] == 3'b001) begin
                b = {12'b0, ins[19:0]} << (2 * ins[23:20]);
                if (ins[28]) begin
                    b = b | r[ins[27:24]];
                end
                if (ins[27:24] != 0) begin
                    r[ins[27:24]] = b;
                end
            end else if (ins[31:28] == 4'b0001) begin
                a = r[ins[15:12]];
                b = ins[27] ? ({24'b0, ins[7:0]} << (2 * ins[11:8])) : r[ins[11:8]];
                cN = 1'b0;
                vN = 1'b0;
                case (ins[24:20])
                    `ALU_ADD, `ALU_ADC: begin
                        sum = {32'b0, a} + {32'b0, b} + ((ins[24:20] == `ALU_ADC) ? cF : 1'b0);
                        res = sum[31:0];
                        cN = sum[32];
                        vN = (ins[24:20] == `ALU_ADD) && (a[31] == b[31]) && (res[31] != a[31]);
                    end
                    `ALU_SUB, `ALU_CMP, `ALU_SBC: begin
                        // Carry set means no borrow
                        sum = {32'b0, b} + ((ins[24:20] == `ALU_SBC) ? cF : 1'b0);
                        res = a - sum[31:0];
                        cN = {32'b0, a} >= sum;
                        vN = (ins[24:20] == `ALU_SUB) && (a[31] != b[31]) && (res[31] != a[31]);
                    end
                    `ALU_AND, `ALU_TST: res = a & b;
                    `ALU_OR:            res = a | b;
                    `ALU_XOR:           res = a ^ b;
                    `ALU_NOT:           res = ~a;
                    `ALU_BSWAP:         res = {a[7:0], a[15:8], a[23:16], a[31:24]};
                    default:            res = `ALU_DEFAULT;
                endcase
                {cF, zF, nF, vF} = {cN, res == 32'h0, res[31], vN};
                if (ins[19:16] != 0) begin
                    r[ins[19:16]] = res;
                end
            end else if (ins[31:27] == 5'b00001) begin
                a = r[ins[23:20]];
                b = r[ins[19:16]];
                if (ins[24] && ins[19:16] != 0) begin
                    r[ins[19:16]] = a;
                end
                // Second write wins on the same register
                if (ins[23:20] != 0) begin
                    r[ins[23:20]] = b;
                end
            end else if (ins[31:26] == 6'b000001 && ins[25:20] == `CORE_HALT) begin
                done = 1'b1;
            end
            pc = nextPc;
        end
    endfunction

    assign memRdata = mem[memAddr[7:0]];

    always @(posedge iClk) begin
        if (memAccess && memWrite && memReady) begin
            mem[memAddr[7:0]] <= memWdata;
        end
    end

    // Ready is low one time in three
    always @(posedge iClk) begin
        #2;
        memReady <= ($urandom % 3) != 0;
    end

    always @(negedge iClk) begin
        if (rstN && memAccess && memWrite && memReady) begin
            if (storeIdx < expAddr.size()) begin
                checks++;
                assert (memAddr == expAddr[storeIdx] && memWdata == expData[storeIdx]) else begin
                    errors++;
                    $display("Fail at %0t: store %0d wrote %h to %h, expected %h to %h",
                             $time, storeIdx, memWdata, memAddr,
                             expData[storeIdx], expAddr[storeIdx]);
                end
            end else begin
                errors++;
                $display("Unexpected extra store of %h to address %h", memWdata, memAddr);
            end
            storeIdx++;
        end
    end

    always @(posedge iClk) begin
        cycles++;
        if (cycles >= maxCycles) begin
            $display("Timeout: the core did not halt within %0d cycles", maxCycles);
            $display("Checks: %0d, errors: %0d", checks,
                     errors + i_cpuCore.uAssert.failCount + 1);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h24f6_edf6));
        memReady = 1'b0;
        storeIdx = 0;
        checks = 0;
        errors = 0;
        cycles = 0;
        for (i = 0; i < 256; i++) begin
            mem[i] = 32'h5A00_0000 | (i * 32'h0001_0101);
        end
        buildProgram();
        for (i = 0; i < prog.size(); i++) begin
            mem[i] = prog[i];
        end
        // Random operand words
        for (i = 'hF0; i < 256; i++) begin
            mem[i] = $urandom;
        end
        refMem = mem;
        refRun();

        wait (halt === 1'b1);
        @(negedge iClk);
        checks++;
        assert (storeIdx == expAddr.size()) else begin
            errors++;
            $display("Fail at %0t: %0d stores seen, expected %0d",
                     $time, storeIdx, expAddr.size());
        end
        for (i = resBase; i < 256; i++) begin
            checks++;
            assert (mem[i] == refMem[i]) else begin
                errors++;
                $display("Fail at %0t: mem[%h] is %h, expected %h", $time, i, mem[i], refMem[i]);
            end
        end
        repeat (20) begin
            @(negedge iClk);
            checks++;
            assert (halt && !memAccess) else begin
                errors++;
                $display("Fail at %0t: halt %b memAccess %b after halt", $time, halt, memAccess);
            end
        end

        errors += i_cpuCore.uAssert.failCount;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+design
design/cpuPkg.sv
design/decodeIf.sv
design/instDecode.sv
design/pipeCtrl.sv
design/regFile.sv
design/aluFlags.sv
design/dataPath.sv
design/cpuCore.sv
sim/tbClock.sv
sim/cpu_assert.sv
sim/cpuTb.sv
